// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_pool_stage
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== act_quant.sv ====
// activation quantizer with arithmetic shift, relu, 8-bit saturation and stream register
`timescale 1ns/1ps
`default_nettype none

module act_quant #(
    parameter int QUANT_SHIFT = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    conv_valid_i,
    input  logic                    conv_last_i,
    input  cnn_data_pkg::acc_data_t conv_data_i,
    input  cnn_data_pkg::act_addr_t conv_addr_i,
    act_stream_if.producer          act_o
);
    import cnn_data_pkg::*;

    acc_data_t shifted;
    logic      is_negative;
    logic      is_overflow;
    act_data_t clamped;

    always_comb begin
        shifted     = conv_data_i >>> QUANT_SHIFT; // sign is kept.
        is_negative = shifted[ACC_WIDTH-1];
        is_overflow = |shifted[ACC_WIDTH-2:ACT_WIDTH]; // anything above 255.
    end

    // relu then clamp to the activation range
    always_comb begin
        if (is_negative) begin
            clamped = '0;
        end else if (is_overflow) begin
            clamped = ACT_MAX;
        end else begin
            clamped = shifted[ACT_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            act_o.valid <= 1'b0;
            act_o.last  <= 1'b0;
        end else begin
            act_o.valid <= conv_valid_i;
            act_o.last  <= conv_valid_i & conv_last_i; // last only with valid.
        end
    end

    always_ff @(posedge clk) begin
        if (conv_valid_i) begin
            act_o.data <= clamped;
            act_o.addr <= conv_addr_i;
        end
    end

endmodule

`default_nettype wire

// ==== act_stream_if.sv ====
// activation stream interface with producer and consumer modports
`timescale 1ns/1ps
`default_nettype none

interface act_stream_if;
    import cnn_data_pkg::*;

    logic      valid; // one sample per cycle while high.
    logic      last;  // only meaningful with valid.
    act_data_t data;
    act_addr_t addr;

    modport producer (
        output valid,
        output last,
        output data,
        output addr
    );

    modport consumer (
        input valid,
        input last,
        input data,
        input addr
    );

endinterface

`default_nettype wire

// ==== cnn_data_pkg.sv ====
// data width constants and typedefs for accumulators, activations and addresses
`default_nettype none

package cnn_data_pkg;

    localparam int ACC_WIDTH  = 20; // convolution accumulator.
    localparam int ACT_WIDTH  = 8;  // activation after quantization.
    localparam int ADDR_WIDTH = 10; // feature-map address.

    // signed accumulator out of the convolution engine
    typedef logic signed [ACC_WIDTH-1:0] acc_data_t;

    // unsigned activation, also used for the pooled value
    typedef logic [ACT_WIDTH-1:0] act_data_t;

    // address of one activation inside the feature map
    typedef logic [ADDR_WIDTH-1:0] act_addr_t;

    localparam act_data_t ACT_MAX = '1; // saturation ceiling.

endpackage

`default_nettype wire

// ==== max_pool_2x2.sv ====
// 2x2 max pooling unit with window fsm, running max and argmax address
`timescale 1ns/1ps
`default_nettype none

module max_pool_2x2 (
    input  logic                    clk,
    input  logic                    rst,
    act_stream_if.consumer          act_i,
    output logic                    pool_valid_o,
    output logic                    pool_last_o,
    output cnn_data_pkg::act_data_t pool_data_o,
    output cnn_data_pkg::act_addr_t pool_addr_o
);
    import cnn_data_pkg::*;
    import pool_ctrl_pkg::*;

    // window position that closes a full group
    localparam pool_state_e LAST_POS = pool_state_e'(POOL_WINDOW - 1);

    pool_state_e state_q;
    pool_state_e state_n;
    act_data_t   max_q;
    act_addr_t   max_addr_q;
    logic        take_sample;
    logic        close_group;
    act_data_t   win_data;
    act_addr_t   win_addr;

    always_comb begin
        case (state_q)
            S_TAKE1: begin
                state_n = S_TAKE2;
            end
            S_TAKE2: begin
                state_n = S_TAKE3;
            end
            S_TAKE3: begin
                state_n = S_TAKE4;
            end
            default: begin
                state_n = S_TAKE1; // wraps after the fourth sample.
            end
        endcase
    end

    // first sample always loads, later ones only when strictly greater
    always_comb begin
        take_sample = (state_q == S_TAKE1) || (act_i.data > max_q);
        close_group = act_i.last || (state_q == LAST_POS);
    end

    always_comb begin
        if (take_sample) begin
            win_data = act_i.data;
            win_addr = act_i.addr;
        end else begin
            win_data = max_q;
            win_addr = max_addr_q; // ties keep the earlier address.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q      <= S_TAKE1;
            max_q        <= '0;
            max_addr_q   <= '0;
            pool_valid_o <= 1'b0;
            pool_last_o  <= 1'b0;
        end else begin
            pool_valid_o <= 1'b0; // single cycle pulse.
            pool_last_o  <= 1'b0;
            if (act_i.valid) begin
                if (close_group) begin
                    pool_valid_o <= 1'b1;
                    pool_last_o  <= act_i.last;
                    state_q      <= S_TAKE1; // restart grouping.
                end else begin
                    state_q      <= state_n;
                    max_q        <= win_data;
                    max_addr_q   <= win_addr;
                end
            end
        end
    end

    // result includes the closing sample itself
    always_ff @(posedge clk) begin
        if (act_i.valid && close_group) begin
            pool_data_o <= win_data;
            pool_addr_o <= win_addr;
        end
    end

endmodule

`default_nettype wire

// ==== pool_ctrl_pkg.sv ====
// pooling window size and window position state encoding
`default_nettype none

package pool_ctrl_pkg;

    localparam int POOL_WINDOW = 4; // samples per 2x2 window.

    // position of the next sample inside the current window
    typedef enum logic [1:0] {
        S_TAKE1 = 2'd0,
        S_TAKE2 = 2'd1,
        S_TAKE3 = 2'd2,
        S_TAKE4 = 2'd3
    } pool_state_e;

endpackage

`default_nettype wire

// ==== pool_stage_properties.sv ====
// output protocol assertions for the max pooling unit and their bind
`timescale 1ns/1ps
`default_nettype none

module pool_stage_properties (
    input logic clk,
    input logic rst,
    input logic act_valid_i,
    input logic close_i,
    input logic pool_valid_i,
    input logic pool_last_i
);

    int unsigned last_fails  = 0;
    int unsigned pulse_fails = 0;
    int unsigned reset_fails = 0;
    int unsigned fail_count;
    logic        closing;

    assign closing    = act_valid_i && close_i; // sample that ends a group.
    assign fail_count = last_fails + pulse_fails + reset_fails;

    last_needs_valid: assert property (@(posedge clk) disable iff (!rst)
        pool_last_i |-> pool_valid_i)
    else begin
        $error("pool_last_o high without pool_valid_o");
        last_fails++;
    end

    // back to back results need two closing samples in a row
    pulse_per_group: assert property (@(posedge clk) disable iff (!rst)
        (pool_valid_i && $past(pool_valid_i)) |-> ($past(closing) && $past(closing, 2)))
    else begin
        $error("pool_valid_o held high without a second closing sample");
        pulse_fails++;
    end

    low_after_reset: assert property (@(posedge clk)
        !rst |=> (!pool_valid_i && !pool_last_i))
    else begin
        $error("pool outputs not low after reset");
        reset_fails++;
    end

endmodule

bind max_pool_2x2 pool_stage_properties u_props (
    .clk          (clk),
    .rst          (rst),
    .act_valid_i  (act_i.valid),
    .close_i      (close_group),
    .pool_valid_i (pool_valid_o),
    .pool_last_i  (pool_last_o)
);

`default_nettype wire

// ==== pool_stage_top.sv ====
// output stage top level joining the activation quantizer and the max pooling unit
`timescale 1ns/1ps
`default_nettype none

module pool_stage_top #(
    parameter int QUANT_SHIFT = 4
) (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    conv_valid_i,
    input  logic                    conv_last_i,
    input  cnn_data_pkg::acc_data_t conv_data_i,
    input  cnn_data_pkg::act_addr_t conv_addr_i,

    output logic                    pool_valid_o,
    output logic                    pool_last_o,
    output cnn_data_pkg::act_data_t pool_data_o,
    output cnn_data_pkg::act_addr_t pool_addr_o
);

    act_stream_if act_s (); // quantized activations, 1 cycle behind conv.

    act_quant #(
        .QUANT_SHIFT (QUANT_SHIFT)
    ) u_act_quant (
        .clk          (clk),
        .rst          (rst),
        .conv_valid_i (conv_valid_i),
        .conv_last_i  (conv_last_i),
        .conv_data_i  (conv_data_i),
        .conv_addr_i  (conv_addr_i),
        .act_o        (act_s.producer)
    );

    max_pool_2x2 u_max_pool (
        .clk          (clk),
        .rst          (rst),
        .act_i        (act_s.consumer),
        .pool_valid_o (pool_valid_o),
        .pool_last_o  (pool_last_o),
        .pool_data_o  (pool_data_o),
        .pool_addr_o  (pool_addr_o)
    );

endmodule

`default_nettype wire

// ==== src.f ====
cnn_data_pkg.sv
pool_ctrl_pkg.sv
act_stream_if.sv
act_quant.sv
max_pool_2x2.sv
pool_stage_top.sv
pool_stage_properties.sv
tb_pool_stage.sv

// ==== tb_pool_stage.sv ====
// testbench for the pooling output stage with stimulus table, reference model and checks
`timescale 1ns/1ps
`default_nettype none

module tb_pool_stage;
    import cnn_data_pkg::*;

    localparam int QUANT_SHIFT    = 4;
    localparam int NUM_FIXED      = 11;
    localparam int NUM_RAND       = 4;
    localparam int NUM_TESTS      = NUM_FIXED + NUM_RAND;
    localparam int TIMEOUT_CYCLES = 20;
    localparam int EXP_LATENCY    = 2; // closing sample to pool_valid_o.

    logic      clk = 1'b0;
    logic      rst;
    logic      conv_valid_i;
    logic      conv_last_i;
    acc_data_t conv_data_i;
    act_addr_t conv_addr_i;
    logic      pool_valid_o;
    logic      pool_last_o;
    act_data_t pool_data_o;
    act_addr_t pool_addr_o;

    // stimulus table with one entry per test
    string     name_tbl [NUM_TESTS];
    acc_data_t acc_tbl  [NUM_TESTS][4];
    int        len_tbl  [NUM_TESTS];
    logic      last_tbl [NUM_TESTS];
    logic      gap_tbl  [NUM_TESTS];

    logic [31:0] rng_state;
    int          addr_cnt;
    int          pass_cnt;
    int          fail_cnt;
    int unsigned prop_fails;

    pool_stage_top #(
        .QUANT_SHIFT (QUANT_SHIFT)
    ) u_dut (
        .clk          (clk),
        .rst          (rst),
        .conv_valid_i (conv_valid_i),
        .conv_last_i  (conv_last_i),
        .conv_data_i  (conv_data_i),
        .conv_addr_i  (conv_addr_i),
        .pool_valid_o (pool_valid_o),
        .pool_last_o  (pool_last_o),
        .pool_data_o  (pool_data_o),
        .pool_addr_o  (pool_addr_o)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // shift, relu and clamp to 0..255
    function automatic int quantize(input acc_data_t acc);
        int v;
        v = int'(acc) >>> QUANT_SHIFT;
        if (v < 0) begin
            return 0;
        end
        if (v > 255) begin
            return 255;
        end
        return v;
    endfunction

    task automatic set_entry(input int idx, input string name, input int a0, input int a1,
                             input int a2, input int a3, input int len, input logic last,
                             input logic gap);
        name_tbl[idx]   = name;
        acc_tbl[idx][0] = acc_data_t'(a0);
        acc_tbl[idx][1] = acc_data_t'(a1);
        acc_tbl[idx][2] = acc_data_t'(a2);
        acc_tbl[idx][3] = acc_data_t'(a3);
        len_tbl[idx]    = len;
        last_tbl[idx]   = last;
        gap_tbl[idx]    = gap;
    endtask

    task automatic load_table();
        logic [31:0] r;
        int          len;
        set_entry(0, "relu_mixed", -100, 320, 1000, -5000, 4, 1'b0, 1'b0);
        set_entry(1, "all_negative", -16, -1, -3000, -80000, 4, 1'b0, 1'b0);
        set_entry(2, "saturate", 5000, 4096, 100000, 16, 4, 1'b0, 1'b0);
        set_entry(3, "tie_keeps_first", 160, 800, 800, 32, 4, 1'b0, 1'b0);
        set_entry(4, "max_in_last_slot", 0, 16, 32, 4080, 4, 1'b0, 1'b0);
        set_entry(5, "gaps_in_group", -100, 320, 1000, -5000, 4, 1'b0, 1'b1);
        set_entry(6, "last_after_one", 2000, 0, 0, 0, 1, 1'b1, 1'b0);
        set_entry(7, "last_after_two", -50, 480, 0, 0, 2, 1'b1, 1'b0);
        set_entry(8, "last_after_three", 700, 90, 700, 0, 3, 1'b1, 1'b1);
        set_entry(9, "fresh_after_last", 48, 32, 16, 0, 4, 1'b0, 1'b0);
        set_entry(10, "full_group_last", -1, 64, 2, 4095, 4, 1'b1, 1'b0);
        for (int i = NUM_FIXED; i < NUM_TESTS; i++) begin
            r   = next_rand();
            len = int'(r[9:8]) + 1;
            set_entry(i, $sformatf("random_%0d", i - NUM_FIXED),
                      int'(next_rand() % 32'd8192) - 2048, int'(next_rand() % 32'd8192) - 2048,
                      int'(next_rand() % 32'd8192) - 2048, int'(next_rand() % 32'd8192) - 2048,
                      len, (len < 4) ? 1'b1 : r[0], 1'b1);
        end
    endtask

    // first sample reaching the strict maximum wins
    task automatic ref_model(input int idx, input int base, output act_data_t exp_data,
                             output act_addr_t exp_addr);
        int best;
        int q;
        best     = -1;
        exp_addr = '0;
        for (int k = 0; k < len_tbl[idx]; k++) begin
            q = quantize(acc_tbl[idx][k]);
            if (q > best) begin
                best     = q;
                exp_addr = act_addr_t'(base + k);
            end
        end
        exp_data = act_data_t'(best);
    endtask

    task automatic check_idle(input int idx, inout logic ok);
        @(negedge clk);
        assert (!pool_valid_o) else begin
            $display("test %s: pool_valid_o high outside its result cycle", name_tbl[idx]);
            ok = 1'b0;
        end
    endtask

    task automatic run_test(input int idx);
        int        base;
        int        gap;
        int        latency;
        logic      got;
        logic      ok;
        act_data_t exp_data;
        act_addr_t exp_addr;
        base = addr_cnt;
        ok   = 1'b1;
        ref_model(idx, base, exp_data, exp_addr);
        for (int k = 0; k < len_tbl[idx]; k++) begin
            if (gap_tbl[idx] && k > 0) begin
                gap = int'(next_rand() % 32'd4) + 1;
                repeat (gap) begin
                    @(posedge clk);
                    conv_valid_i <= 1'b0;
                    conv_last_i  <= 1'b0;
                    check_idle(idx, ok);
                end
            end
            @(posedge clk);
            conv_valid_i <= 1'b1;
            conv_last_i  <= last_tbl[idx] && (k == len_tbl[idx] - 1);
            conv_data_i  <= acc_tbl[idx][k];
            conv_addr_i  <= act_addr_t'(addr_cnt);
            addr_cnt++;
            check_idle(idx, ok);
        end
        latency = 0;
        got     = 1'b0;
        while (!got && latency < TIMEOUT_CYCLES) begin
            @(posedge clk);
            conv_valid_i <= 1'b0;
            conv_last_i  <= 1'b0;
            latency++;
            @(negedge clk);
            got = pool_valid_o;
        end
        if (!got) begin
            $display("test %s: result never arrived within %0d cycles", name_tbl[idx],
                     TIMEOUT_CYCLES);
            ok = 1'b0;
        end else begin
            assert (latency == EXP_LATENCY) else begin
                $display("error %s latency expected %0d actual %0d", name_tbl[idx],
                         EXP_LATENCY, latency);
                ok = 1'b0;
            end
            assert (pool_data_o == exp_data) else begin
                $display("error %s data expected %0d actual %0d", name_tbl[idx],
                         exp_data, pool_data_o);
                ok = 1'b0;
            end
            assert (pool_addr_o == exp_addr) else begin
                $display("error %s addr expected %0d actual %0d", name_tbl[idx],
                         exp_addr, pool_addr_o);
                ok = 1'b0;
            end
            assert (pool_last_o == last_tbl[idx]) else begin
                $display("error %s last expected %0b actual %0b", name_tbl[idx],
                         last_tbl[idx], pool_last_o);
                ok = 1'b0;
            end
            check_idle(idx, ok); // the pulse lasts one cycle.
        end
        if (ok) begin
            pass_cnt++;
            $display("test %s: ok", name_tbl[idx]);
        end else begin
            fail_cnt++;
            $display("test %s: failed", name_tbl[idx]);
        end
    endtask

    initial begin
        rng_state    = 32'd90;
        addr_cnt     = 0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        rst          = 1'b0;
        conv_valid_i = 1'b0;
        conv_last_i  = 1'b0;
        conv_data_i  = '0;
        conv_addr_i  = '0;
        load_table();
        repeat (5) @(posedge clk);
        rst <= 1'b1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(i);
        end
        repeat (2) @(posedge clk);
        prop_fails = u_dut.u_max_pool.u_props.fail_count;
        $display("%0d tests passed, %0d tests failed, %0d property failures",
                 pass_cnt, fail_cnt, prop_fails);
        if (fail_cnt == 0 && prop_fails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
